// ==== Bender.yml ====
package:
  name: riscvCore

sources:
  - files:
      - rtl/corePkg.sv
      - rtl/instrDecoder.sv
      - rtl/immGen.sv
      - rtl/alu.sv
      - rtl/regFile.sv
      - rtl/nextPcUnit.sv
      - rtl/loadStoreUnit.sv
      - rtl/riscvCore.sv
  - target: test
    files:
      - verification/riscvCore_sva.sv
      - verification/riscvCoreTb.sv

// ==== files.f ====
rtl/corePkg.sv
rtl/instrDecoder.sv
rtl/immGen.sv
rtl/alu.sv
rtl/regFile.sv
rtl/nextPcUnit.sv
rtl/loadStoreUnit.sv
rtl/riscvCore.sv
verification/riscvCore_sva.sv
verification/riscvCoreTb.sv

// ==== rtl/alu.sv ====
`default_nettype none

module alu (
    input  wire corePkg::aluOp_e op,
    input  wire corePkg::xlen_t  a,
    input  wire corePkg::xlen_t  b,
    output corePkg::xlen_t       result
);

    logic [5:0] shamt;                 // RV64 shift amount
    logic       ltSigned;
    logic       ltUnsigned;

    assign shamt      = b[5:0];
    assign ltSigned   = $signed(a) < $signed(b);
    assign ltUnsigned = a < b;

    always_comb begin
        case (op)
            corePkg::ALU_ADD:   result = a + b;
            corePkg::ALU_SUB:   result = a - b;
            corePkg::ALU_SLL:   result = a << shamt;
            corePkg::ALU_SLT:   result = {63'b0, ltSigned};
            corePkg::ALU_SLTU:  result = {63'b0, ltUnsigned};
            corePkg::ALU_XOR:   result = a ^ b;
            corePkg::ALU_SRL:   result = a >> shamt;
            corePkg::ALU_SRA:   result = $signed(a) >>> shamt;   // Fill with a[63]
            corePkg::ALU_OR:    result = a | b;
            corePkg::ALU_AND:   result = a & b;
            corePkg::ALU_PASSB: result = b;                      // lui
            default:            result = '0;                     // ALU_BAD
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/corePkg.sv ====
`default_nettype none

package corePkg;

    typedef logic [63:0] xlen_t;       // Register and data word
    typedef logic [31:0] instr_t;      // Raw instruction
    typedef logic [4:0]  regAddr_t;    // x0..x31

    localparam xlen_t RESET_PC = 64'h0000_0000_8000_0000;

    // Major opcodes, instr[6:0]
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_SLL   = 4'd2,
        ALU_SLT   = 4'd3,
        ALU_SLTU  = 4'd4,
        ALU_XOR   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_OR    = 4'd8,
        ALU_AND   = 4'd9,
        ALU_PASSB = 4'd10,             // lui
        ALU_BAD   = 4'd15              // Illegal encoding
    } aluOp_e;

    // Same coding as memToReg
    typedef enum logic [1:0] {
        WB_ALU   = 2'b00,
        WB_MEM   = 2'b01,
        WB_PC4   = 2'b10,              // jal / jalr link
        WB_PCIMM = 2'b11               // auipc
    } wbSel_e;

    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_EQ   = 3'd1,
        BR_NE   = 3'd2,
        BR_LT   = 3'd3,
        BR_GE   = 3'd4
    } branch_e;

    typedef enum logic [1:0] {
        JMP_NONE = 2'd0,
        JMP_JAL  = 2'd1,
        JMP_JALR = 2'd2
    } jump_e;

    // Access length in bytes
    typedef enum logic [2:0] {
        LEN_NONE = 3'd0,
        LEN_BYTE = 3'd1,
        LEN_HALF = 3'd2,
        LEN_WORD = 3'd4
    } memLen_e;

    typedef struct packed {
        aluOp_e  aluOp;
        wbSel_e  wbSel;
        branch_e branch;
        logic    branchUnsigned;       // bltu / bgeu
        jump_e   jump;
        logic    regWrite;
        logic    memWrite;
        logic    memRead;
        memLen_e memLen;
        logic    memSigned;
        logic    aluSrcImm;            // Second ALU operand from imm
    } ctrl_t;

    typedef struct packed {
        xlen_t   addr;
        xlen_t   wdata;                // Store bytes in the low end
        memLen_e len;
        logic    we;
    } dataReq_t;

endpackage

`default_nettype wire

// ==== rtl/immGen.sv ====
`default_nettype none

module immGen (
    input  wire corePkg::instr_t instr,
    output corePkg::xlen_t       imm
);

    logic [6:0] opcode;
    logic       sign;                  // Immediate sign is always instr[31]

    assign opcode = instr[6:0];
    assign sign   = instr[31];

    always_comb begin
        case (opcode)
            // I format
            corePkg::OPC_LOAD,
            corePkg::OPC_OPIMM,
            corePkg::OPC_JALR:
                imm = {{52{sign}}, instr[31:20]};
            // S format
            corePkg::OPC_STORE:
                imm = {{52{sign}}, instr[31:25], instr[11:7]};
            // B format, bit 0 implied zero
            corePkg::OPC_BRANCH:
                imm = {{51{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
            // U format, sign-extended above bit 31
            corePkg::OPC_LUI,
            corePkg::OPC_AUIPC:
                imm = {{32{sign}}, instr[31:12], 12'b0};
            // J format
            corePkg::OPC_JAL:
                imm = {{43{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
            default:
                imm = '0;                  // R type has none
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/instrDecoder.sv ====
`default_nettype none

module instrDecoder (
    input  wire corePkg::instr_t instr,
    output corePkg::ctrl_t       ctrl
);

    logic [6:0] opcode;
    logic [2:0] func3;
    logic [6:0] func7;
    logic [5:0] shamtF;                // Bits above the 6-bit shamt

    assign opcode = instr[6:0];
    assign func3  = instr[14:12];
    assign func7  = instr[31:25];
    assign shamtF = instr[31:26];

    always_comb begin
        ctrl       = '0;               // No writes, no branch, ALU result to rd
        ctrl.aluOp = corePkg::ALU_ADD; // Address adds for loads, stores, jumps

        case (opcode)
            corePkg::OPC_OP: begin
                ctrl.regWrite = 1'b1;
                case ({func7, func3})
                    10'b0000000_000: ctrl.aluOp = corePkg::ALU_ADD;
                    10'b0100000_000: ctrl.aluOp = corePkg::ALU_SUB;
                    10'b0000000_001: ctrl.aluOp = corePkg::ALU_SLL;
                    10'b0000000_010: ctrl.aluOp = corePkg::ALU_SLT;
                    10'b0000000_011: ctrl.aluOp = corePkg::ALU_SLTU;
                    10'b0000000_100: ctrl.aluOp = corePkg::ALU_XOR;
                    10'b0000000_101: ctrl.aluOp = corePkg::ALU_SRL;
                    10'b0100000_101: ctrl.aluOp = corePkg::ALU_SRA;
                    10'b0000000_110: ctrl.aluOp = corePkg::ALU_OR;
                    10'b0000000_111: ctrl.aluOp = corePkg::ALU_AND;
                    default:         ctrl.aluOp = corePkg::ALU_BAD;
                endcase
            end
            corePkg::OPC_OPIMM: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                case (func3)
                    3'b000: ctrl.aluOp = corePkg::ALU_ADD;
                    3'b010: ctrl.aluOp = corePkg::ALU_SLT;
                    3'b011: ctrl.aluOp = corePkg::ALU_SLTU;
                    3'b100: ctrl.aluOp = corePkg::ALU_XOR;
                    3'b110: ctrl.aluOp = corePkg::ALU_OR;
                    3'b111: ctrl.aluOp = corePkg::ALU_AND;
                    3'b001: begin      // slli
                        if (shamtF == 6'b000000) ctrl.aluOp = corePkg::ALU_SLL;
                        else                     ctrl.aluOp = corePkg::ALU_BAD;
                    end
                    default: begin     // srli / srai
                        if (shamtF == 6'b000000)      ctrl.aluOp = corePkg::ALU_SRL;
                        else if (shamtF == 6'b010000) ctrl.aluOp = corePkg::ALU_SRA;
                        else                          ctrl.aluOp = corePkg::ALU_BAD;
                    end
                endcase
            end
            corePkg::OPC_LOAD: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.wbSel     = corePkg::WB_MEM;
                ctrl.memSigned = ~func3[2];    // lb lh lw, lw sign-extends on RV64
                case (func3)
                    3'b000, 3'b100: ctrl.memLen = corePkg::LEN_BYTE;
                    3'b001, 3'b101: ctrl.memLen = corePkg::LEN_HALF;
                    3'b010:         ctrl.memLen = corePkg::LEN_WORD;
                    default:        ctrl.aluOp  = corePkg::ALU_BAD;  // ld, lwu
                endcase
            end
            corePkg::OPC_STORE: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                case (func3)
                    3'b000:  ctrl.memLen = corePkg::LEN_BYTE;
                    3'b001:  ctrl.memLen = corePkg::LEN_HALF;
                    3'b010:  ctrl.memLen = corePkg::LEN_WORD;
                    default: ctrl.aluOp  = corePkg::ALU_BAD;         // sd
                endcase
            end
            corePkg::OPC_BRANCH: begin
                ctrl.aluOp          = corePkg::ALU_SUB;
                ctrl.branchUnsigned = func3[1];
                case (func3)
                    3'b000:         ctrl.branch = corePkg::BR_EQ;
                    3'b001:         ctrl.branch = corePkg::BR_NE;
                    3'b100, 3'b110: ctrl.branch = corePkg::BR_LT;
                    3'b101, 3'b111: ctrl.branch = corePkg::BR_GE;
                    default:        ctrl.aluOp  = corePkg::ALU_BAD;
                endcase
            end
            corePkg::OPC_JAL: begin
                ctrl.jump     = corePkg::JMP_JAL;
                ctrl.regWrite = 1'b1;
                ctrl.wbSel    = corePkg::WB_PC4;
            end
            corePkg::OPC_JALR: begin
                ctrl.jump      = corePkg::JMP_JALR;
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.wbSel     = corePkg::WB_PC4;
                if (func3 != 3'b000) ctrl.aluOp = corePkg::ALU_BAD;
            end
            corePkg::OPC_LUI: begin
                ctrl.aluOp     = corePkg::ALU_PASSB;  // imm straight through
                ctrl.aluSrcImm = 1'b1;
                ctrl.regWrite  = 1'b1;
            end
            corePkg::OPC_AUIPC: begin
                ctrl.regWrite = 1'b1;
                ctrl.wbSel    = corePkg::WB_PCIMM;
            end
            default: ctrl.aluOp = corePkg::ALU_BAD;
        endcase

        // Illegal instruction turns into a bubble
        if (ctrl.aluOp == corePkg::ALU_BAD) begin
            ctrl       = '0;
            ctrl.aluOp = corePkg::ALU_BAD;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/loadStoreUnit.sv ====
`default_nettype none

module loadStoreUnit (
    input  wire                 rstN,
    input  wire corePkg::ctrl_t ctrl,
    input  wire corePkg::xlen_t addr,
    input  wire corePkg::xlen_t storeData,
    input  wire corePkg::xlen_t dataRData,
    output corePkg::dataReq_t   dataReq,
    output corePkg::xlen_t      loadData
);

    corePkg::xlen_t lenMask;           // Bytes covered by the access
    corePkg::xlen_t extended;

    always_comb begin
        case (ctrl.memLen)
            corePkg::LEN_BYTE: lenMask = 64'h0000_0000_0000_00ff;
            corePkg::LEN_HALF: lenMask = 64'h0000_0000_0000_ffff;
            corePkg::LEN_WORD: lenMask = 64'h0000_0000_ffff_ffff;
            default:           lenMask = '0;
        endcase
    end

    always_comb begin
        dataReq.addr  = addr;
        dataReq.wdata = storeData & lenMask;     // Upper bytes zero
        dataReq.len   = ctrl.memLen;
        dataReq.we    = ctrl.memWrite & rstN;    // No stores in reset
    end

    // Read data arrives in the low bytes
    always_comb begin
        case (ctrl.memLen)
            corePkg::LEN_BYTE:
                extended = {{56{ctrl.memSigned & dataRData[7]}}, dataRData[7:0]};
            corePkg::LEN_HALF:
                extended = {{48{ctrl.memSigned & dataRData[15]}}, dataRData[15:0]};
            corePkg::LEN_WORD:
                extended = {{32{ctrl.memSigned & dataRData[31]}}, dataRData[31:0]};
            default:
                extended = '0;
        endcase
    end

    assign loadData = ctrl.memRead ? extended : '0;

endmodule

`default_nettype wire

// ==== rtl/nextPcUnit.sv ====
`default_nettype none

module nextPcUnit (
    input  wire                 clk,
    input  wire                 rstN,
    input  wire corePkg::ctrl_t ctrl,
    input  wire corePkg::xlen_t rs1Data,
    input  wire corePkg::xlen_t rs2Data,
    input  wire corePkg::xlen_t imm,
    output corePkg::xlen_t      pc,
    output corePkg::xlen_t      pcPlus4
);

    logic           isEqual;
    logic           isLess;            // Signed or unsigned per ctrl
    logic           taken;
    corePkg::xlen_t pcTarget;
    corePkg::xlen_t jalrSum;
    corePkg::xlen_t nextPc;

    assign isEqual = rs1Data == rs2Data;
    assign isLess  = ctrl.branchUnsigned ? (rs1Data < rs2Data)
                                         : ($signed(rs1Data) < $signed(rs2Data));

    always_comb begin
        case (ctrl.branch)
            corePkg::BR_EQ: taken = isEqual;
            corePkg::BR_NE: taken = !isEqual;
            corePkg::BR_LT: taken = isLess;
            corePkg::BR_GE: taken = !isLess;
            default:        taken = 1'b0;
        endcase
    end

    assign pcPlus4  = pc + 64'd4;
    assign pcTarget = pc + imm;        // Branch and jal target
    assign jalrSum  = rs1Data + imm;

    always_comb begin
        if (ctrl.jump == corePkg::JMP_JALR)
            nextPc = {jalrSum[63:1], 1'b0};   // LSB cleared
        else if (taken || ctrl.jump == corePkg::JMP_JAL)
            nextPc = pcTarget;
        else
            nextPc = pcPlus4;
    end

    always_ff @(posedge clk) begin
        if (!rstN) pc <= corePkg::RESET_PC;
        else       pc <= nextPc;
    end

endmodule

`default_nettype wire

// ==== rtl/regFile.sv ====
`default_nettype none

module regFile (
    input  wire                    clk,
    input  wire                    rstN,
    input  wire corePkg::regAddr_t rs1,
    input  wire corePkg::regAddr_t rs2,
    input  wire corePkg::regAddr_t rd,
    input  wire                    we,
    input  wire corePkg::xlen_t    wdata,
    output corePkg::xlen_t         rdata1,
    output corePkg::xlen_t         rdata2
);

    corePkg::xlen_t regs [1:31];       // No storage for x0

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // Combinational reads, x0 hardwired
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== rtl/riscvCore.sv ====
`default_nettype none

module riscvCore (
    input  wire                    clk,
    input  wire                    rstN,
    output corePkg::xlen_t         pc,
    input  wire corePkg::instr_t   instr,
    output corePkg::dataReq_t      dataReq,
    input  wire corePkg::xlen_t    dataRData
);

    corePkg::ctrl_t    ctrl;
    corePkg::regAddr_t rs1Addr;
    corePkg::regAddr_t rs2Addr;
    corePkg::regAddr_t rdAddr;
    corePkg::xlen_t    imm;
    corePkg::xlen_t    rs1Data;
    corePkg::xlen_t    rs2Data;
    corePkg::xlen_t    aluB;
    corePkg::xlen_t    aluResult;
    corePkg::xlen_t    loadData;
    corePkg::xlen_t    pcPlus4;
    corePkg::xlen_t    pcImm;          // auipc result
    corePkg::xlen_t    wbData;

    assign rs1Addr = instr[19:15];
    assign rs2Addr = instr[24:20];
    assign rdAddr  = instr[11:7];

    instrDecoder uDecoder (.instr(instr), .ctrl(ctrl));

    immGen uImmGen (.instr(instr), .imm(imm));

    regFile uRegFile (
        .clk   (clk),
        .rstN  (rstN),
        .rs1   (rs1Addr),
        .rs2   (rs2Addr),
        .rd    (rdAddr),
        .we    (ctrl.regWrite),
        .wdata (wbData),
        .rdata1(rs1Data),
        .rdata2(rs2Data)
    );

    assign aluB = ctrl.aluSrcImm ? imm : rs2Data;   // I, S, lui take imm

    alu uAlu (.op(ctrl.aluOp), .a(rs1Data), .b(aluB), .result(aluResult));

    nextPcUnit uNextPc (
        .clk    (clk),
        .rstN   (rstN),
        .ctrl   (ctrl),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data),
        .imm    (imm),
        .pc     (pc),
        .pcPlus4(pcPlus4)
    );

    loadStoreUnit uLsu (
        .rstN     (rstN),
        .ctrl     (ctrl),
        .addr     (aluResult),         // rs1 + imm
        .storeData(rs2Data),
        .dataRData(dataRData),
        .dataReq  (dataReq),
        .loadData (loadData)
    );

    assign pcImm = pc + imm;

    always_comb begin
        case (ctrl.wbSel)
            corePkg::WB_MEM:   wbData = loadData;
            corePkg::WB_PC4:   wbData = pcPlus4;      // Link address
            corePkg::WB_PCIMM: wbData = pcImm;
            default:           wbData = aluResult;
        endcase
    end

endmodule

`default_nettype wire

// ==== verification/riscvCoreTb.sv ====
`default_nettype none

module riscvCoreTb;

    localparam int CLK_PERIOD = 8;
    localparam int MAX_ROWS   = 128;
    localparam int IMEM_WORDS = 128;
    localparam int DMEM_WORDS = 64;    // 512 bytes from address 0

    logic                clk = 1'b0;
    logic                rstN;
    corePkg::xlen_t      pc;
    corePkg::instr_t     instr;
    corePkg::dataReq_t   dataReq;
    corePkg::xlen_t      dataRData;

    corePkg::instr_t imem [IMEM_WORDS];
    corePkg::xlen_t  dmem [DMEM_WORDS];
    corePkg::xlen_t  expMem [DMEM_WORDS];   // Memory as the program should leave it
    corePkg::xlen_t  xr [32];               // Expected register contents while building

    // Program table, one row per retired instruction
    corePkg::xlen_t rowNext [MAX_ROWS];
    logic           rowWe [MAX_ROWS];
    corePkg::xlen_t rowAddr [MAX_ROWS];
    corePkg::xlen_t rowData [MAX_ROWS];
    logic [2:0]     rowLen [MAX_ROWS];
    int             nRows = 0;
    corePkg::xlen_t bpc;                    // pc of the row being built
    logic           tableReady = 1'b0;

    int errCount = 0;
    int seed     = 94;

    riscvCore dut (
        .clk      (clk),
        .rstN     (rstN),
        .pc       (pc),
        .instr    (instr),
        .dataReq  (dataReq),
        .dataRData(dataRData)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic corePkg::instr_t fetchWord(corePkg::xlen_t addr);
        corePkg::xlen_t offs;
        offs = addr - corePkg::RESET_PC;
        if (offs < 4 * IMEM_WORDS) return imem[offs >> 2];
        return '0;                          // Illegal, core turns it into a bubble
    endfunction

    // Byte lanes of a store merged into a memory word
    function automatic corePkg::xlen_t mergeStore(corePkg::xlen_t old, logic [2:0] offs,
                                                  corePkg::xlen_t data, logic [2:0] len);
        corePkg::xlen_t w;
        w = old;
        for (int i = 0; i < 8; i++) begin
            if (i < len) w[(offs + i) * 8 +: 8] = data[i * 8 +: 8];
        end
        return w;
    endfunction

    always @(negedge clk) instr <= fetchWord(pc);

    // Data memory, read data shifted down to the low bytes
    assign dataRData = dmem[dataReq.addr[8:3]] >> {dataReq.addr[2:0], 3'b000};

    always @(posedge clk) begin
        if (dataReq.we) begin
            dmem[dataReq.addr[8:3]] <= mergeStore(dmem[dataReq.addr[8:3]], dataReq.addr[2:0],
                                                  dataReq.wdata, dataReq.len);
        end
    end

    function automatic corePkg::xlen_t sext12(logic [11:0] v);
        return {{52{v[11]}}, v};
    endfunction

    function automatic corePkg::xlen_t upperImm(logic [19:0] v);
        return {{32{v[19]}}, v, 12'b0};
    endfunction

    // RV64I OP / OP-IMM results, alt is the instr[30] variant
    function automatic corePkg::xlen_t refOp(logic alt, logic [2:0] f3,
                                             corePkg::xlen_t a, corePkg::xlen_t b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[5:0];
            3'b010: return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            3'b011: return (a < b) ? 64'd1 : 64'd0;
            3'b100: return a ^ b;
            3'b101: begin
                if (alt) return $signed(a) >>> b[5:0];
                return a >> b[5:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    // Load result from the expected memory, lb lh lw lbu lhu
    function automatic corePkg::xlen_t loadRef(logic [2:0] f3, logic [11:0] a);
        corePkg::xlen_t raw;
        raw = expMem[a[8:3]] >> (8 * a[2:0]);
        case (f3)
            3'b000:  return {{56{raw[7]}}, raw[7:0]};
            3'b001:  return {{48{raw[15]}}, raw[15:0]};
            3'b010:  return {{32{raw[31]}}, raw[31:0]};
            3'b100:  return {56'b0, raw[7:0]};
            3'b101:  return {48'b0, raw[15:0]};
            default: return '0;
        endcase
    endfunction

    function automatic corePkg::instr_t encR(logic [6:0] f7, int rs2, int rs1,
                                             logic [2:0] f3, int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), corePkg::OPC_OP};
    endfunction

    function automatic corePkg::instr_t encI(logic [11:0] imm, int rs1, logic [2:0] f3,
                                             int rd, logic [6:0] opc);
        return {imm, 5'(rs1), f3, 5'(rd), opc};
    endfunction

    function automatic corePkg::instr_t encS(logic [11:0] imm, int rs2, logic [2:0] f3);
        return {imm[11:5], 5'(rs2), 5'd0, f3, imm[4:0], corePkg::OPC_STORE};   // Base x0
    endfunction

    function automatic corePkg::instr_t encB(logic [12:0] imm, int rs2, int rs1,
                                             logic [2:0] f3);
        return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11],
                corePkg::OPC_BRANCH};
    endfunction

    function automatic corePkg::instr_t encJ(logic [20:0] imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), corePkg::OPC_JAL};
    endfunction

    task automatic addRow(corePkg::instr_t ins, corePkg::xlen_t nextPc, logic we,
                          corePkg::xlen_t addr, corePkg::xlen_t data, logic [2:0] len);
        imem[(bpc - corePkg::RESET_PC) >> 2] = ins;
        rowNext[nRows] = nextPc;
        rowWe[nRows]   = we;
        rowAddr[nRows] = addr;
        rowData[nRows] = data;
        rowLen[nRows]  = len;
        nRows++;
        bpc   = nextPc;
        xr[0] = '0;                         // x0 writes are lost
    endtask

    task automatic regOp(logic alt, logic [2:0] f3, int rd, int rs1, int rs2);
        xr[rd] = refOp(alt, f3, xr[rs1], xr[rs2]);
        addRow(encR(alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd), bpc + 4, 1'b0, '0, '0, 3'd0);
    endtask

    task automatic immOp(logic [2:0] f3, int rd, int rs1, logic [11:0] imm);
        xr[rd] = refOp(f3 == 3'b101 && imm[10], f3, xr[rs1], sext12(imm));
        addRow(encI(imm, rs1, f3, rd, corePkg::OPC_OPIMM), bpc + 4, 1'b0, '0, '0, 3'd0);
    endtask

    task automatic loadUpper(int rd, logic [19:0] imm, logic addPc);
        xr[rd] = upperImm(imm) + (addPc ? bpc : 64'd0);
        addRow({imm, 5'(rd), addPc ? corePkg::OPC_AUIPC : corePkg::OPC_LUI}, bpc + 4,
               1'b0, '0, '0, 3'd0);
    endtask

    task automatic loadFrom(logic [2:0] f3, int rd, logic [11:0] off);
        xr[rd] = loadRef(f3, off);
        addRow(encI(off, 0, f3, rd, corePkg::OPC_LOAD), bpc + 4, 1'b0, '0, '0, 3'd0);
    endtask

    task automatic storeTo(logic [2:0] f3, int rs2, logic [11:0] off);
        logic [2:0]     len;
        corePkg::xlen_t data;
        len  = 3'd1 << f3;                  // 1, 2 or 4 bytes
        data = xr[rs2] & ((64'd1 << (8 * len)) - 64'd1);
        expMem[off[8:3]] = mergeStore(expMem[off[8:3]], off[2:0], data, len);
        addRow(encS(off, rs2, f3), bpc + 4, 1'b1, sext12(off), data, len);
    endtask

    task automatic branchTo(logic [2:0] f3, int rs1, int rs2, int off);
        logic taken;
        case (f3)
            3'b000:  taken = xr[rs1] == xr[rs2];
            3'b001:  taken = xr[rs1] != xr[rs2];
            3'b100:  taken = $signed(xr[rs1]) < $signed(xr[rs2]);
            3'b101:  taken = $signed(xr[rs1]) >= $signed(xr[rs2]);
            3'b110:  taken = xr[rs1] < xr[rs2];
            default: taken = xr[rs1] >= xr[rs2];
        endcase
        addRow(encB(13'(off), rs2, rs1, f3), taken ? bpc + off : bpc + 4,
               1'b0, '0, '0, 3'd0);
    endtask

    task automatic jumpAndLink(int rd, int off);
        xr[rd] = bpc + 4;
        addRow(encJ(21'(off), rd), bpc + off, 1'b0, '0, '0, 3'd0);
    endtask

    task automatic jumpRegister(int rd, int rs1, logic [11:0] imm);
        corePkg::xlen_t target;
        target = (xr[rs1] + sext12(imm)) & ~64'd1;
        xr[rd] = bpc + 4;
        addRow(encI(imm, rs1, 3'b000, rd, corePkg::OPC_JALR), target, 1'b0, '0, '0, 3'd0);
    endtask

    task automatic buildProgram();
        for (int i = 0; i < 32; i++) xr[i] = '0;
        for (int i = 0; i < IMEM_WORDS; i++) imem[i] = '0;
        bpc = corePkg::RESET_PC;
        storeTo(3'b000, 0, 12'd7);          // sb, already presented during reset
        loadUpper(1, 20'h80000, 1'b0);      // lui, negative
        immOp(3'b000, 2, 0, 12'hffb);       // -5
        immOp(3'b000, 3, 0, 12'h7ff);
        regOp(1'b0, 3'b000, 4, 1, 3);       // add
        regOp(1'b1, 3'b000, 5, 2, 3);       // sub
        regOp(1'b0, 3'b010, 6, 2, 3);       // slt
        regOp(1'b0, 3'b011, 7, 2, 3);       // sltu
        regOp(1'b0, 3'b100, 8, 1, 2);
        regOp(1'b0, 3'b110, 9, 4, 2);
        regOp(1'b0, 3'b111, 10, 1, 2);
        for (int r = 4; r <= 10; r++) storeTo(3'b010, r, 12'(r * 4 - 8));
        immOp(3'b010, 11, 2, 12'hffd);      // slti
        immOp(3'b011, 12, 2, 12'h001);      // sltiu, -5 is huge unsigned
        immOp(3'b100, 13, 1, 12'hfff);      // Bitwise not
        immOp(3'b110, 14, 3, 12'h555);
        immOp(3'b111, 15, 1, 12'h7f0);
        immOp(3'b101, 16, 13, 12'h020);     // Upper word of x13
        for (int r = 11; r <= 16; r++) storeTo(3'b010, r, 12'(r * 4 - 8));
        immOp(3'b000, 17, 0, 12'd36);       // Shift amount above 31
        regOp(1'b0, 3'b001, 18, 2, 17);
        regOp(1'b0, 3'b101, 19, 2, 17);
        regOp(1'b1, 3'b101, 20, 2, 17);
        immOp(3'b001, 21, 2, 12'd40);
        immOp(3'b101, 22, 1, 12'd33);
        immOp(3'b101, 23, 1, 12'h421);      // srai 33
        immOp(3'b101, 18, 18, 12'h420);     // Left shifts leave the low word zero
        immOp(3'b101, 21, 21, 12'h420);
        for (int r = 18; r <= 23; r++) storeTo(3'b010, r, 12'(r * 4 - 12));
        loadFrom(3'b000, 24, 12'd99);       // Random data from here on
        loadFrom(3'b100, 25, 12'd99);
        loadFrom(3'b001, 26, 12'd102);
        loadFrom(3'b101, 27, 12'd102);
        loadFrom(3'b010, 28, 12'd108);
        immOp(3'b101, 29, 28, 12'd32);      // lw sign extension
        storeTo(3'b010, 24, 12'd120);
        storeTo(3'b010, 25, 12'd124);
        storeTo(3'b001, 26, 12'd130);       // sh into a random word
        storeTo(3'b000, 27, 12'd133);
        storeTo(3'b010, 28, 12'd136);
        storeTo(3'b010, 29, 12'd140);
        branchTo(3'b000, 2, 2, 8);          // beq taken
        branchTo(3'b001, 2, 2, 8);
        branchTo(3'b100, 2, 3, 8);          // blt taken
        branchTo(3'b101, 2, 3, 8);
        branchTo(3'b110, 2, 3, 8);          // bltu not taken
        branchTo(3'b111, 2, 3, 8);
        branchTo(3'b001, 2, 3, 12);
        branchTo(3'b000, 2, 3, 8);
        jumpAndLink(30, 12);
        storeTo(3'b010, 30, 12'd144);       // Link value
        loadUpper(31, 20'h00001, 1'b1);     // auipc
        storeTo(3'b010, 31, 12'd148);
        loadUpper(29, 20'h00000, 1'b1);
        jumpRegister(30, 29, 12'd13);       // Odd target, bit 0 dropped
        storeTo(3'b010, 30, 12'd152);
    endtask

    task automatic checkVal(string name, corePkg::xlen_t got, corePkg::xlen_t exp);
        assert (got === exp) else begin
            errCount++;
            $display("ERR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    initial begin
        corePkg::xlen_t expPc;
        rstN  = 1'b0;
        instr = '0;
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i]   = {$random(seed), $random(seed)};
            expMem[i] = dmem[i];
        end
        buildProgram();
        tableReady = 1'b1;
        @(negedge clk);
        #2;
        checkVal("pc", pc, corePkg::RESET_PC);
        checkVal("dataReq.we", 64'(dataReq.we), 64'd0);   // First row is a store
        @(negedge clk);
        rstN  = 1'b1;
        expPc = corePkg::RESET_PC;
        for (int r = 0; r < nRows; r++) begin
            #2;
            checkVal("pc", pc, expPc);
            checkVal("dataReq.we", 64'(dataReq.we), 64'(rowWe[r]));
            if (rowWe[r]) begin
                checkVal("dataReq.addr", dataReq.addr, rowAddr[r]);
                checkVal("dataReq.wdata", dataReq.wdata, rowData[r]);
                checkVal("dataReq.len", 64'(dataReq.len), 64'(rowLen[r]));
            end
            expPc = rowNext[r];
            @(negedge clk);
        end
        #2;
        checkVal("pc", pc, expPc);
        for (int i = 0; i < DMEM_WORDS; i++) begin
            checkVal($sformatf("dmem[%0d]", i), dmem[i], expMem[i]);
        end
        $display("Errors: %0d failed checks, %0d assertion failures",
                 errCount, dut.uSva.failCount);
        if (errCount == 0 && dut.uSva.failCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Twice the expected run time plus some margin
    initial begin
        wait (tableReady);
        #((nRows + 10) * CLK_PERIOD * 2);
        $display("Timeout: the program did not finish in time");
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/riscvCore_sva.sv ====
`default_nettype none

module riscvCore_sva (
    input wire                    clk,
    input wire                    rstN,
    input wire corePkg::xlen_t    pc,
    input wire corePkg::dataReq_t dataReq
);

    int         failCount = 0;         // Read by the testbench at the end
    logic [2:0] lenBits;

    assign lenBits = dataReq.len;

    pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
        else begin failCount++; $error("pc not word aligned"); end

    // Memory must never see a write during reset
    noStoreInReset: assert property (@(posedge clk) !rstN |-> !dataReq.we)
        else begin failCount++; $error("store requested while in reset"); end

    storeAligned: assert property (@(posedge clk) disable iff (!rstN)
        dataReq.we |-> (dataReq.addr[2:0] & (lenBits - 3'd1)) == 3'd0)
        else begin failCount++; $error("store address not aligned to its length"); end

    resetPc: assert property (@(posedge clk) $rose(rstN) |-> pc == corePkg::RESET_PC)
        else begin failCount++; $error("pc not at reset value after reset"); end

endmodule

bind riscvCore riscvCore_sva uSva (
    .clk    (clk),
    .rstN   (rstN),
    .pc     (pc),
    .dataReq(dataReq)
);

`default_nettype wire
